// File: Bender.yml
package:
  name: rv_core

sources:
  - common/rv_pkg.sv
  - design/rv_idu.sv
  - design/rv_regfile.sv
  - design/rv_exu.sv
  - design/rv_pcu.sv
  - design/rv_ctrl.sv
  - design/rv_core.sv
  - target: simulation
    files:
      - tb/tb_core.sv

// File: all.f
common/rv_pkg.sv
design/rv_idu.sv
design/rv_regfile.sv
design/rv_exu.sv
design/rv_pcu.sv
design/rv_ctrl.sv
design/rv_core.sv
tb/tb_core.sv

// File: common/rv_pkg.sv
package rv_pkg;

    localparam int xlen_w = 32;
    localparam int reg_addr_w = 4;

    localparam logic [xlen_w-1:0] reset_pc = 32'h0000_0000;

    // base opcodes, bits [6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    // branch_cond encoding
    localparam logic [1:0] br_eq = 2'd0;
    localparam logic [1:0] br_ne = 2'd1;
    localparam logic [1:0] br_lt = 2'd2;
    localparam logic [1:0] br_ge = 2'd3;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_s;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_s;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_s;

    // one fetched word, viewed per format
    typedef union packed {
        r_fmt_s r_fmt;
        i_fmt_s i_fmt;
        s_fmt_s s_fmt;
        b_fmt_s b_fmt;
        u_fmt_s u_fmt;
        j_fmt_s j_fmt;
    } inst_u;

    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen_w-1:0]     imm;
        alu_op_e               alu_op;
        logic                  src_a_pc;
        logic                  src_b_imm;
        logic                  reg_wen;
        logic                  is_load;
        logic                  is_store;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        logic [1:0]            branch_cond;
        logic                  halt;
    } dec_s;

    typedef struct packed {
        logic [xlen_w-1:0] addr;
        logic [xlen_w-1:0] wdata;
        logic              wen;
    } mem_req_s;

    typedef struct packed {
        logic [xlen_w-1:0]     pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen_w-1:0]     wdata;
        logic                  wen;
    } commit_s;

endpackage

// File: design/rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      mem_ok,
    input  logic [rv_pkg::xlen_w-1:0] mem_rdata,
    output logic                      mem_req,
    output rv_pkg::mem_req_s          mem,
    output logic                      commit,
    output rv_pkg::commit_s           commit_info,
    output logic                      halted,
    output logic [rv_pkg::xlen_w-1:0] pc
);
    import rv_pkg::*;

    inst_u                 inst;
    dec_s                  dec;
    logic [xlen_w-1:0]     rs1_data;
    logic [xlen_w-1:0]     rs2_data;
    logic [xlen_w-1:0]     alu_result;
    logic                  take_branch;
    logic [xlen_w-1:0]     pc_next;
    logic [xlen_w-1:0]     link_addr;
    logic                  rf_wen;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen_w-1:0]     rf_wdata;

    rv_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec         (dec),
        .alu_result  (alu_result),
        .link_addr   (link_addr),
        .pc_next     (pc_next),
        .rs2_data    (rs2_data),
        .mem_ok      (mem_ok),
        .mem_rdata   (mem_rdata),
        .inst        (inst),
        .pc          (pc),
        .rf_wen      (rf_wen),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .mem_req     (mem_req),
        .mem         (mem),
        .commit      (commit),
        .commit_info (commit_info),
        .halted      (halted)
    );

    rv_idu u_idu (
        .inst (inst),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .waddr  (rf_waddr),
        .wen    (rf_wen),
        .wdata  (rf_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // exu and pcu both work off the same decoded word
    rv_exu u_exu (
        .dec         (dec),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .take_branch (take_branch)
    );

    rv_pcu u_pcu (
        .dec         (dec),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .take_branch (take_branch),
        .pc_next     (pc_next),
        .link_addr   (link_addr)
    );

endmodule

// File: design/rv_ctrl.sv
`timescale 1ns/10ps

module rv_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  rv_pkg::dec_s                  dec,
    input  logic [rv_pkg::xlen_w-1:0]     alu_result,
    input  logic [rv_pkg::xlen_w-1:0]     link_addr,
    input  logic [rv_pkg::xlen_w-1:0]     pc_next,
    input  logic [rv_pkg::xlen_w-1:0]     rs2_data,
    input  logic                          mem_ok,
    input  logic [rv_pkg::xlen_w-1:0]     mem_rdata,
    output rv_pkg::inst_u                 inst,
    output logic [rv_pkg::xlen_w-1:0]     pc,
    output logic                          rf_wen,
    output logic [rv_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [rv_pkg::xlen_w-1:0]     rf_wdata,
    output logic                          mem_req,
    output rv_pkg::mem_req_s              mem,
    output logic                          commit,
    output rv_pkg::commit_s               commit_info,
    output logic                          halted
);
    import rv_pkg::*;

    typedef enum logic [2:0] {
        fetch_req,
        fetch_wait,
        exec,
        mem_wait,
        wb
    } state_e;

    state_e            state;
    logic [xlen_w-1:0] load_data;
    logic              wr_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fetch_req;
            pc <= reset_pc;
            mem_req <= 1'b0;
            halted <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            case (state)
                fetch_req: begin
                    mem_req <= 1'b1;
                    state <= fetch_wait;
                end
                fetch_wait: begin
                    if (mem_ok) begin
                        state <= exec;
                    end
                end
                exec: begin
                    // halting instruction parks the FSM here for good
                    if (dec.halt) begin
                        halted <= 1'b1;
                    end else if (dec.is_load || dec.is_store) begin
                        mem_req <= 1'b1;
                        state <= mem_wait;
                    end else begin
                        state <= wb;
                    end
                end
                mem_wait: begin
                    if (mem_ok) begin
                        state <= wb;
                    end
                end
                wb: begin
                    pc <= pc_next;
                    state <= fetch_req;
                end
                default: state <= fetch_req;
            endcase
        end
    end

    // fetched word, load data and the request payload
    always_ff @(posedge clk) begin
        if (state == fetch_wait && mem_ok) begin
            inst <= mem_rdata;
        end
        if (state == mem_wait && mem_ok) begin
            load_data <= mem_rdata;
        end
        if (state == fetch_req) begin
            mem <= '{addr: pc, wdata: '0, wen: 1'b0};
        end else if (state == exec) begin
            mem <= '{addr: alu_result, wdata: rs2_data, wen: dec.is_store};
        end
    end

    // x0 writes are dropped here
    assign wr_en = dec.reg_wen && dec.rd != '0;

    always_comb begin
        if (dec.is_load) begin
            rf_wdata = load_data;
        end else if (dec.is_jal || dec.is_jalr) begin
            rf_wdata = link_addr;
        end else begin
            rf_wdata = alu_result;
        end
    end

    assign rf_wen = (state == wb) && wr_en;
    assign rf_waddr = dec.rd;

    assign commit = (state == wb);
    assign commit_info.pc = pc;
    assign commit_info.rd = wr_en ? dec.rd : '0;
    assign commit_info.wdata = wr_en ? rf_wdata : '0;
    assign commit_info.wen = wr_en;

    // one access outstanding on the shared port
    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req |=> !mem_req until mem_ok);

    a_commit_not_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(commit && mem_req));

    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted);

endmodule

// File: design/rv_exu.sv
`timescale 1ns/10ps

module rv_exu (
    input  rv_pkg::dec_s                  dec,
    input  logic [rv_pkg::xlen_w-1:0]     pc,
    input  logic [rv_pkg::xlen_w-1:0]     rs1_data,
    input  logic [rv_pkg::xlen_w-1:0]     rs2_data,
    output logic [rv_pkg::xlen_w-1:0]     alu_result,
    output logic                          take_branch
);
    import rv_pkg::*;

    logic [xlen_w-1:0] op_a;
    logic [xlen_w-1:0] op_b;
    logic              cond;

    assign op_a = dec.src_a_pc ? pc : rs1_data;
    assign op_b = dec.src_b_imm ? dec.imm : rs2_data;

    // also the load/store address
    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_result = op_a + op_b;
            alu_sub:  alu_result = op_a - op_b;
            alu_and:  alu_result = op_a & op_b;
            alu_or:   alu_result = op_a | op_b;
            alu_xor:  alu_result = op_a ^ op_b;
            alu_slt:  alu_result = {{(xlen_w-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {{(xlen_w-1){1'b0}}, op_a < op_b};
            default:  alu_result = op_b;
        endcase
    end

    // comparator always looks at the two registers
    always_comb begin
        case (dec.branch_cond)
            br_eq:   cond = (rs1_data == rs2_data);
            br_ne:   cond = (rs1_data != rs2_data);
            br_lt:   cond = ($signed(rs1_data) < $signed(rs2_data));
            default: cond = ($signed(rs1_data) >= $signed(rs2_data));
        endcase
    end

    assign take_branch = dec.is_branch && cond;

endmodule

// File: design/rv_idu.sv
`timescale 1ns/10ps

module rv_idu (
    input  rv_pkg::inst_u inst,
    output rv_pkg::dec_s  dec
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       use_rs1;
    logic       use_rs2;
    logic       use_rd;
    logic       illegal;

    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    assign funct7 = inst.r_fmt.funct7;

    always_comb begin
        dec = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd = 1'b0;
        illegal = 1'b0;
        dec.rs1 = inst.r_fmt.rs1[reg_addr_w-1:0];
        dec.rs2 = inst.r_fmt.rs2[reg_addr_w-1:0];
        dec.rd = inst.r_fmt.rd[reg_addr_w-1:0];
        dec.alu_op = alu_add;
        case (opcode)
            op_lui: begin
                dec.imm = {inst.u_fmt.imm, 12'b0};
                dec.alu_op = alu_pass_b;
                dec.src_b_imm = 1'b1;
                use_rd = 1'b1;
            end
            op_auipc: begin
                dec.imm = {inst.u_fmt.imm, 12'b0};
                dec.src_a_pc = 1'b1;
                dec.src_b_imm = 1'b1;
                use_rd = 1'b1;
            end
            op_jal: begin
                dec.imm = {{12{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
                           inst.j_fmt.imm10_1, 1'b0};
                dec.is_jal = 1'b1;
                use_rd = 1'b1;
            end
            op_jalr: begin
                dec.imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                dec.is_jalr = 1'b1;
                use_rs1 = 1'b1;
                use_rd = 1'b1;
                illegal = (funct3 != 3'b000);
            end
            op_branch: begin
                dec.imm = {{20{inst.b_fmt.imm12}}, inst.b_fmt.imm11, inst.b_fmt.imm10_5,
                           inst.b_fmt.imm4_1, 1'b0};
                dec.is_branch = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case (funct3)
                    3'b000: dec.branch_cond = br_eq;
                    3'b001: dec.branch_cond = br_ne;
                    3'b100: dec.branch_cond = br_lt;
                    3'b101: dec.branch_cond = br_ge;
                    default: illegal = 1'b1;
                endcase
            end
            op_load, op_store: begin
                // word accesses only
                dec.is_load = (opcode == op_load);
                dec.is_store = (opcode == op_store);
                dec.src_b_imm = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = dec.is_store;
                use_rd = dec.is_load;
                if (dec.is_store) begin
                    dec.imm = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
                end else begin
                    dec.imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                end
                illegal = (funct3 != 3'b010);
            end
            op_imm, op_reg: begin
                dec.imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
                dec.src_b_imm = (opcode == op_imm);
                use_rs1 = 1'b1;
                use_rs2 = (opcode == op_reg);
                use_rd = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = (use_rs2 && funct7[5]) ? alu_sub : alu_add;
                    3'b100: dec.alu_op = alu_xor;
                    3'b110: dec.alu_op = alu_or;
                    3'b111: dec.alu_op = alu_and;
                    3'b010: dec.alu_op = alu_slt;
                    3'b011: begin
                        dec.alu_op = alu_sltu;
                        // no SLTIU here
                        illegal = ~use_rs2;
                    end
                    default: illegal = 1'b1;
                endcase
                // only SUB may carry a nonzero funct7
                if (use_rs2 && funct7 != 7'b0000000 &&
                    !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    illegal = 1'b1;
                end
            end
            // EBREAK, and anything else in the system space, stops the core
            op_system: illegal = 1'b1;
            default: illegal = 1'b1;
        endcase
        // RV32E: upper half of the register space does not exist
        if ((use_rs1 && inst.r_fmt.rs1[4]) || (use_rs2 && inst.r_fmt.rs2[4]) ||
            (use_rd && inst.r_fmt.rd[4])) begin
            illegal = 1'b1;
        end
        dec.reg_wen = use_rd && !illegal;
        dec.halt = illegal;
    end

endmodule

// File: design/rv_pcu.sv
`timescale 1ns/10ps

module rv_pcu (
    input  rv_pkg::dec_s              dec,
    input  logic [rv_pkg::xlen_w-1:0] pc,
    input  logic [rv_pkg::xlen_w-1:0] rs1_data,
    input  logic                      take_branch,
    output logic [rv_pkg::xlen_w-1:0] pc_next,
    output logic [rv_pkg::xlen_w-1:0] link_addr
);
    import rv_pkg::*;

    logic [xlen_w-1:0] jalr_sum;
    logic [xlen_w-1:0] target;
    logic              redirect;

    assign link_addr = pc + 32'd4;
    assign jalr_sum = rs1_data + dec.imm;

    // jalr clears bit 0 of the sum
    assign target = dec.is_jalr ? {jalr_sum[xlen_w-1:1], 1'b0} : pc + dec.imm;

    assign redirect = dec.is_jal || dec.is_jalr || take_branch;
    assign pc_next = redirect ? target : link_addr;

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  logic                          wen,
    input  logic [rv_pkg::xlen_w-1:0]     wdata,
    output logic [rv_pkg::xlen_w-1:0]     rdata1,
    output logic [rv_pkg::xlen_w-1:0]     rdata2
);
    import rv_pkg::*;

    // x1..x15, x0 is not stored
    logic [xlen_w-1:0] regs [1:15];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // the controller drops x0 writes before they get here
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wen && waddr == '0));

endmodule

// File: tb/core_stimulus.txt
# P byte_addr word | C pc rd wen wdata | S byte_addr wdata (all hex)
# unlisted words hold an illegal fill pattern
P 00 00500093
P 04 ffd00113
P 08 002081b3
P 0c 40208233
P 10 0020f2b3
P 14 0020e333
P 18 0020c3b3
P 1c 00112433
P 20 001134b3
P 24 ffe12513
P 28 0f037593
P 2c 1000e613
P 30 fff0c693
P 34 12345737
P 38 00001797
P 3c 00708013
P 40 20e02023
P 44 20002083
P 48 00318463
P 50 00319463
P 54 00314463
P 5c 00315463
P 60 00419463
P 68 00324463
P 6c 00325463
P 74 00418463
P 78 00c002ef
P 84 09400313
P 88 009303e7
P 9c 16532823
P a0 20402403
P a4 00100073
# ALU ops, LUI, AUIPC, write to x0
C 00 1 1 00000005
C 04 2 1 fffffffd
C 08 3 1 00000002
C 0c 4 1 00000008
C 10 5 1 00000005
C 14 6 1 fffffffd
C 18 7 1 fffffff8
C 1c 8 1 00000001
C 20 9 1 00000000
C 24 a 1 00000001
C 28 b 1 000000f0
C 2c c 1 00000105
C 30 d 1 fffffffa
C 34 e 1 12345000
C 38 f 1 00001038
C 3c 0 0 00000000
# store and load back
C 40 0 0 00000000
C 44 1 1 12345000
# branches, then JAL and JALR with odd target
C 48 0 0 00000000
C 50 0 0 00000000
C 54 0 0 00000000
C 5c 0 0 00000000
C 60 0 0 00000000
C 68 0 0 00000000
C 6c 0 0 00000000
C 74 0 0 00000000
C 78 5 1 0000007c
C 84 6 1 00000094
C 88 7 1 0000008c
C 9c 0 0 00000000
C a0 8 1 0000007c
S 200 12345000
S 204 0000007c

// File: tb/tb_core.sv
`timescale 1ns/10ps

module tb_core;
    import rv_pkg::*;

    localparam int timeout_cycles = 200;

    logic            clk;
    logic            rst_n;
    logic            mem_ok;
    logic [31:0]     mem_rdata;
    logic            mem_req;
    mem_req_s        req;
    logic            commit;
    commit_s         commit_info;
    logic            halted;
    logic [31:0]     pc;

    logic [31:0]     ram [0:255];
    commit_s         exp_commits [$];
    mem_req_s        exp_stores [$];
    int              store_idx = 0;
    int              commit_count = 0;
    int              value_errs = 0;
    int              other_errs = 0;
    integer          seed = 32'h41e;

    rv_core u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_ok      (mem_ok),
        .mem_rdata   (mem_rdata),
        .mem_req     (mem_req),
        .mem         (req),
        .commit      (commit),
        .commit_info (commit_info),
        .halted      (halted),
        .pc          (pc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_commit(input int idx, input commit_s got, input commit_s exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED at %0t: commit %0d got pc %h rd %0d wen %b data %h",
                     $time, idx, got.pc, got.rd, got.wen, got.wdata);
            $display("    expected pc %h rd %0d wen %b data %h",
                     exp.pc, exp.rd, exp.wen, exp.wdata);
        end
    endtask

    task automatic check_store(input string what, input mem_req_s got, input mem_req_s exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED at %0t: %s got addr %h data %h wen %b, expected %h %h %b",
                     $time, what, got.addr, got.wdata, got.wen, exp.addr, exp.wdata, exp.wen);
        end
    endtask

    task automatic check_pc(input int idx, input logic [xlen_w-1:0] got,
                            input logic [xlen_w-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED at %0t: pc output at commit %0d is %h, expected %h",
                     $time, idx, got, exp);
        end
    endtask

    // lines are tagged P, C or S and '#' starts a comment line
    task automatic read_stimulus(output bit ok);
        int          fd;
        int          code;
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  rd;
        logic        wen;
        logic [8*256-1:0] rest;
        ok = 1'b0;
        fd = $fopen("tb/core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/core_stimulus.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            case (tag)
                "#": code = $fgets(rest, fd);
                "P": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    ram[a[9:2]] = d;
                end
                "C": begin
                    code = $fscanf(fd, "%h %h %h %h", a, rd, wen, d);
                    exp_commits.push_back('{pc: a, rd: rd, wdata: d, wen: wen});
                end
                "S": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    exp_stores.push_back('{addr: a, wdata: d, wen: 1'b1});
                end
                default: begin
                    $display("stimulus file has a line with unknown tag '%c'", tag);
                    $fclose(fd);
                    return;
                end
            endcase
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    // memory model serving one access at a time with random latency
    initial begin
        mem_req_s held;
        int       lat;
        mem_ok = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req) begin
                held = req;
                lat = 1 + ({$random(seed)} % 4);
                if (held.wen) begin
                    if (store_idx >= exp_stores.size()) begin
                        other_errs++;
                        $display("unexpected store to %h at %0t", held.addr, $time);
                    end else begin
                        check_store("store", held, exp_stores[store_idx]);
                    end
                    store_idx++;
                end
                if (held.addr[31:10] != '0 || held.addr[1:0] != 2'b00) begin
                    other_errs++;
                    $display("access to %h falls outside the word memory", held.addr);
                end
                repeat (lat) @(posedge clk);
                #1;
                if (held.wen) begin
                    ram[held.addr[9:2]] = held.wdata;
                    mem_rdata = '0;
                end else begin
                    mem_rdata = ram[held.addr[9:2]];
                end
                mem_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_ok = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && commit) begin
            commit_count++;
        end
    end

    task automatic wait_commit(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < timeout_cycles) begin
            @(negedge clk);
            seen = commit;
            n++;
        end
    endtask

    task automatic run_program();
        bit seen;
        int n;
        // first fetch comes from the reset pc
        seen = 1'b0;
        n = 0;
        while (!seen && n < timeout_cycles) begin
            @(negedge clk);
            seen = mem_req;
            n++;
        end
        if (!seen) begin
            other_errs++;
            $display("timeout: the first fetch request never arrived");
            return;
        end
        check_store("first fetch", req, '{addr: reset_pc, wdata: '0, wen: 1'b0});
        // nothing retires before its answer
        seen = 1'b0;
        n = 0;
        while (!seen && n < timeout_cycles) begin
            @(negedge clk);
            if (commit) begin
                other_errs++;
                $display("commit seen before the first fetch completed");
            end
            seen = mem_ok;
            n++;
        end
        if (!seen) begin
            other_errs++;
            $display("timeout: mem_ok for the first fetch never arrived");
            return;
        end

        for (int i = 0; i < exp_commits.size(); i++) begin
            wait_commit(seen);
            if (!seen) begin
                other_errs++;
                $display("timeout: commit %0d at pc %h never arrived", i, exp_commits[i].pc);
                return;
            end
            check_commit(i, commit_info, exp_commits[i]);
            check_pc(i, pc, exp_commits[i].pc);
        end

        seen = 1'b0;
        n = 0;
        while (!seen && n < timeout_cycles) begin
            @(negedge clk);
            if (commit) begin
                other_errs++;
                $display("unexpected commit at pc %h", commit_info.pc);
            end
            seen = halted;
            n++;
        end
        if (!seen) begin
            other_errs++;
            $display("timeout: halted never went high after the last commit");
            return;
        end

        // a halted core stays quiet
        repeat (20) begin
            @(negedge clk);
            if (commit || mem_req || !halted) begin
                other_errs++;
                $display("core was active after halt at %0t", $time);
            end
        end
        if (commit_count != exp_commits.size()) begin
            value_errs++;
            $display("CHECK FAILED at %0t: %0d commits, expected %0d",
                     $time, commit_count, exp_commits.size());
        end
        if (store_idx != exp_stores.size()) begin
            value_errs++;
            $display("CHECK FAILED at %0t: %0d stores, expected %0d",
                     $time, store_idx, exp_stores.size());
        end
    endtask

    initial begin
        bit loaded;
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ram[i] = {8'(~i), 8'(i), 16'h0000};
        end
        read_stimulus(loaded);
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (loaded) begin
            run_program();
        end else begin
            other_errs++;
        end
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
